//--- Makefile
# Verilator build and run for the cartridge detection testbench

SIM = obj_dir/sim_cart_info

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -j 0 --top-module cart_info_tb \
		-f all.f -o sim_cart_info

run: compile
	./$(SIM) > run.log 2>&1 || true
	@cat run.log
	@if grep -q "Test FAILED" run.log || ! grep -q "Test OK" run.log; then \
		echo "Simulation failed, see run.log"; exit 1; \
	fi

clean:
	rm -rf obj_dir run.log

//--- all.f
hw/cart_pkg.sv
hw/load_stream_decoder.sv
hw/header_capture.sv
hw/chip_classifier.sv
hw/cart_info_top.sv
verif/cart_info_asserts.sv
verif/cart_info_tb.sv

//--- hw/cart_info_top.sv
//==========================================================
// Cartridge detection top level
// Stream decoder, header capture and chip classifier
// Outputs are valid from the 2nd edge after load_active falls
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module cart_info_top
	import cart_pkg::*;
(
	input  wire         clk_sys,
	input  wire         RESET_N,
	input  wire         load_wr,
	input  wire         load_active,
	input  wire [5:0]   load_index,
	input  load_addr_t  load_addr,
	input  load_data_t  load_data,
	input  file_size_t  load_size,
	input  rom_layout_t rom_layout,
	input  wire         reset_req,
	output rom_type_t   rom_type,
	output mask_t       rom_mask,
	output mask_t       ram_mask,
	output logic        sound_mode
);

	logic        cart_wr;
	logic        cart_active;
	load_addr_t  cart_addr;
	load_data_t  cart_data;
	byte_t       mapper_hdr;
	byte_t       type_hdr;
	byte_t       company_hdr;
	size_code_t  rom_size_code;
	size_code_t  ram_size_code;
	rom_layout_t first_layout;

	load_stream_decoder load_stream_decoder_i (
		.clk_sys     (clk_sys),
		.RESET_N     (RESET_N),
		.load_wr     (load_wr),
		.load_active (load_active),
		.load_index  (load_index),
		.load_addr   (load_addr),
		.load_data   (load_data),
		.load_size   (load_size),
		.reset_req   (reset_req),
		.cart_wr     (cart_wr),
		.cart_active (cart_active),
		.cart_addr   (cart_addr),
		.cart_data   (cart_data),
		.sound_mode  (sound_mode)
	);

	header_capture header_capture_i (
		.clk_sys       (clk_sys),
		.RESET_N       (RESET_N),
		.cart_wr       (cart_wr),
		.cart_addr     (cart_addr),
		.cart_data     (cart_data),
		.rom_layout    (rom_layout),
		.mapper_hdr    (mapper_hdr),
		.type_hdr      (type_hdr),
		.company_hdr   (company_hdr),
		.rom_size_code (rom_size_code),
		.ram_size_code (ram_size_code),
		.first_layout  (first_layout)
	);

	chip_classifier chip_classifier_i (
		.clk_sys       (clk_sys),
		.RESET_N       (RESET_N),
		.cart_active   (cart_active),
		.mapper_hdr    (mapper_hdr),
		.type_hdr      (type_hdr),
		.company_hdr   (company_hdr),
		.rom_size_code (rom_size_code),
		.ram_size_code (ram_size_code),
		.first_layout  (first_layout),
		.rom_type      (rom_type),
		.rom_mask      (rom_mask),
		.ram_mask      (ram_mask)
	);

endmodule

`default_nettype wire

//--- hw/cart_pkg.sv
//==========================================================
// Shared types and constants for cartridge detection
// Header offsets are word addresses in the ROM image after
// the copier header is stripped
// Size codes are exponents in 1 KiB units
//==========================================================

`default_nettype none

package cart_pkg;

	// Widths with a meaning
	typedef logic [7:0]  byte_t;
	typedef logic [24:0] load_addr_t;
	typedef logic [15:0] load_data_t;
	typedef logic [23:0] file_size_t;
	typedef logic [3:0]  size_code_t;
	typedef logic [1:0]  rom_layout_t;
	typedef logic [7:0]  rom_type_t;
	typedef logic [23:0] mask_t;
	typedef logic [14:0] hdr_ofs_t;
	typedef logic [8:0]  hdr_prefix_t;
	typedef logic [3:0]  chip_code_t;

	//==========================================================
	// Internal ROM header location
	//==========================================================
	localparam hdr_ofs_t HDR_MAPPER_OFS  = 15'h7FD4;
	localparam hdr_ofs_t HDR_TYPE_OFS    = 15'h7FD6;
	localparam hdr_ofs_t HDR_RAMSIZE_OFS = 15'h7FD8;
	localparam hdr_ofs_t HDR_COMPANY_OFS = 15'h7FDA;

	// Bits placed above the offset, LoROM uses none
	localparam hdr_prefix_t HIROM_PREFIX   = 9'h001;
	localparam hdr_prefix_t EXHIROM_PREFIX = 9'h081;

	localparam rom_layout_t LAYOUT_LOROM   = 2'd0;
	localparam rom_layout_t LAYOUT_HIROM   = 2'd1;
	localparam rom_layout_t LAYOUT_EXHIROM = 2'd2;

	// Menu index of a sound file
	localparam logic [5:0] SPC_INDEX = 6'd2;

	//==========================================================
	// Mask derivation
	//==========================================================
	localparam size_code_t ROM_MIN_EXP   = 4'd12;
	localparam size_code_t ROM_SMALL_EXP = 4'd7;
	localparam size_code_t ST0XX_BIG_EXP = 4'd10;
	localparam size_code_t GSU_RAM_EXP   = 4'd6;
	localparam mask_t      MASK_UNIT     = 24'd1024;

	// Coprocessor codes for rom_type[7:4]
	localparam chip_code_t CHIP_DSP1    = 4'h8;
	localparam chip_code_t CHIP_DSP2    = 4'h9;
	localparam chip_code_t CHIP_DSP3    = 4'hA;
	localparam chip_code_t CHIP_DSP4    = 4'hB;
	localparam chip_code_t CHIP_OBC1    = 4'hC;
	localparam chip_code_t CHIP_SDD1    = 4'h5;
	// ST0XX also sets bit 3
	localparam chip_code_t CHIP_ST0XX   = 4'h8;
	localparam chip_code_t CHIP_GSU     = 4'h7;
	localparam chip_code_t CHIP_SA1     = 4'h6;
	localparam chip_code_t CHIP_SPC7110 = 4'hD;
	localparam chip_code_t CHIP_CX4     = 4'h4;

endpackage

`default_nettype wire

//--- hw/chip_classifier.sv
//==========================================================
// Coprocessor classification and address masks
// Outputs follow the header fields while no cartridge is
// being downloaded, and hold during a download
// Rules are checked in priority order, first match wins
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module chip_classifier
	import cart_pkg::*;
(
	input  wire         clk_sys,
	input  wire         RESET_N,
	input  wire         cart_active,
	input  byte_t       mapper_hdr,
	input  byte_t       type_hdr,
	input  byte_t       company_hdr,
	input  size_code_t  rom_size_code,
	input  size_code_t  ram_size_code,
	input  rom_layout_t first_layout,
	output rom_type_t   rom_type,
	output mask_t       rom_mask,
	output mask_t       ram_mask
);

	rom_type_t  type_next;
	mask_t      rom_mask_next;
	mask_t      ram_mask_next;
	size_code_t rom_exp;

	//==========================================================
	// Masks
	//==========================================================
	// Small or missing ROM sizes fall back to 4 MiB
	assign rom_exp = (rom_size_code < ROM_SMALL_EXP) ? ROM_MIN_EXP : rom_size_code;
	assign rom_mask_next = (MASK_UNIT << rom_exp) - mask_t'(1);

	//==========================================================
	// Chip decode
	//==========================================================
	always_comb begin
		type_next = {6'd0, first_layout};
		ram_mask_next = (ram_size_code == '0) ? '0 :
		                (MASK_UNIT << ram_size_code) - mask_t'(1);

		// DSP3 shares mapper and type with DSP1
		if (mapper_hdr == 8'h30 && type_hdr == 8'h05 && company_hdr == 8'hB2) begin
			type_next[7:4] = CHIP_DSP3;
		end else if (((mapper_hdr == 8'h20 || mapper_hdr == 8'h21) && type_hdr == 8'h03) ||
		             (mapper_hdr == 8'h30 && type_hdr == 8'h05) ||
		             (mapper_hdr == 8'h31 && (type_hdr == 8'h03 || type_hdr == 8'h05))) begin
			type_next[7:4] = CHIP_DSP1;
		end else if (mapper_hdr == 8'h20 && type_hdr == 8'h05) begin
			type_next[7:4] = CHIP_DSP2;
		end else if (mapper_hdr == 8'h30 && type_hdr == 8'h03) begin
			type_next[7:4] = CHIP_DSP4;
		end else if (mapper_hdr == 8'h30 && type_hdr == 8'h25) begin
			type_next[7:4] = CHIP_OBC1;
		end else if (mapper_hdr == 8'h32 && (type_hdr == 8'h43 || type_hdr == 8'h45)) begin
			type_next[7:4] = CHIP_SDD1;
		end else if (mapper_hdr == 8'h30 && type_hdr == 8'hF6) begin
			type_next[7:4] = CHIP_ST0XX;
			type_next[3]   = 1'b1;
			// Smaller ST010/ST011 carts use the other variant
			if (rom_size_code < ST0XX_BIG_EXP)
				type_next[5] = 1'b1;
		end else if (mapper_hdr == 8'h20 &&
		             (type_hdr == 8'h13 || type_hdr == 8'h14 ||
		              type_hdr == 8'h15 || type_hdr == 8'h1A)) begin
			type_next[7:4] = CHIP_GSU;
			// GSU always gets 64 KiB of work RAM
			ram_mask_next  = (MASK_UNIT << GSU_RAM_EXP) - mask_t'(1);
		end else if (mapper_hdr == 8'h23 &&
		             (type_hdr == 8'h32 || type_hdr == 8'h34 || type_hdr == 8'h35)) begin
			type_next[7:4] = CHIP_SA1;
		end else if (mapper_hdr == 8'h3A && (type_hdr == 8'hF5 || type_hdr == 8'hF9)) begin
			type_next[7:4] = CHIP_SPC7110;
			// RTC variant
			type_next[3]   = type_hdr[3];
		end else if (mapper_hdr == 8'h20 && type_hdr == 8'hF3) begin
			type_next[7:4] = CHIP_CX4;
		end
	end

	// Recompute only outside a cartridge download
	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			rom_type <= '0;
			rom_mask <= '0;
			ram_mask <= '0;
		end else if (!cart_active) begin
			rom_type <= type_next;
			rom_mask <= rom_mask_next;
			ram_mask <= ram_mask_next;
		end
	end

endmodule

`default_nettype wire

//--- hw/header_capture.sv
//==========================================================
// Internal ROM header capture
// Fields are latched on the cycle after cart_wr
// The layout must be stable for the whole download
// Fields hold until the same offset is written again
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module header_capture
	import cart_pkg::*;
(
	input  wire         clk_sys,
	input  wire         RESET_N,
	input  wire         cart_wr,
	input  load_addr_t  cart_addr,
	input  load_data_t  cart_data,
	input  rom_layout_t rom_layout,
	output byte_t       mapper_hdr,
	output byte_t       type_hdr,
	output byte_t       company_hdr,
	output size_code_t  rom_size_code,
	output size_code_t  ram_size_code,
	output rom_layout_t first_layout
);

	hdr_prefix_t hdr_prefix;
	load_addr_t  mapper_addr;
	load_addr_t  type_addr;
	load_addr_t  ramsize_addr;
	load_addr_t  company_addr;

	// Header base depends on the layout
	always_comb begin
		case (rom_layout)
			LAYOUT_HIROM:   hdr_prefix = HIROM_PREFIX;
			LAYOUT_EXHIROM: hdr_prefix = EXHIROM_PREFIX;
			default:        hdr_prefix = '0;
		endcase
	end

	assign mapper_addr  = {1'b0, hdr_prefix, HDR_MAPPER_OFS};
	assign type_addr    = {1'b0, hdr_prefix, HDR_TYPE_OFS};
	assign ramsize_addr = {1'b0, hdr_prefix, HDR_RAMSIZE_OFS};
	assign company_addr = {1'b0, hdr_prefix, HDR_COMPANY_OFS};

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			mapper_hdr    <= '0;
			type_hdr      <= '0;
			company_hdr   <= '0;
			rom_size_code <= '0;
			ram_size_code <= '0;
			first_layout  <= '0;
		end else if (cart_wr) begin
			// Start of image, forget the old RAM size
			if (cart_addr == '0) begin
				ram_size_code <= '0;
				first_layout  <= rom_layout;
			end

			if (cart_addr == mapper_addr)
				mapper_hdr <= cart_data[15:8];

			// Type in the low byte, ROM size in the next nibble
			if (cart_addr == type_addr) begin
				type_hdr      <= cart_data[7:0];
				rom_size_code <= cart_data[11:8];
			end

			if (cart_addr == ramsize_addr)
				ram_size_code <= cart_data[3:0];

			if (cart_addr == company_addr)
				company_hdr <= cart_data[7:0];
		end
	end

endmodule

`default_nettype wire

//--- hw/load_stream_decoder.sv
//==========================================================
// Download stream front end
// All outputs are registered, one cycle after the input
// Indices 0 and 1 are cartridge images, index 2 a sound file
// The copier header length is taken from load_size[9:0]
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module load_stream_decoder
	import cart_pkg::*;
(
	input  wire        clk_sys,
	input  wire        RESET_N,
	input  wire        load_wr,
	input  wire        load_active,
	input  wire [5:0]  load_index,
	input  load_addr_t load_addr,
	input  load_data_t load_data,
	input  file_size_t load_size,
	input  wire        reset_req,
	output logic       cart_wr,
	output logic       cart_active,
	output load_addr_t cart_addr,
	output load_data_t cart_data,
	output logic       sound_mode
);

	logic cart_dl;
	logic spc_dl;

	// Download kind from the menu index
	assign cart_dl = load_active && (load_index[5:1] == 5'd0);
	assign spc_dl  = load_active && (load_index == SPC_INDEX);

	always_ff @(posedge clk_sys) begin
		if (!RESET_N) begin
			cart_wr     <= 1'b0;
			cart_active <= 1'b0;
			sound_mode  <= 1'b0;
		end else begin
			cart_wr     <= load_wr & cart_dl;
			cart_active <= cart_dl;
			if (reset_req)
				sound_mode <= 1'b0;
			// A write of any other file leaves sound mode
			if (load_wr)
				sound_mode <= spc_dl;
		end
	end

	// Strip the 512 byte copier header when present
	always_ff @(posedge clk_sys) begin
		cart_addr <= load_addr - load_addr_t'(load_size[9:0]);
		cart_data <= load_data;
	end

endmodule

`default_nettype wire

//--- verif/cart_info_asserts.sv
//==========================================================
// Assertions on the classifier outputs and the write stream
// Bound into cart_info_top to reach the internal wires
// fail_count is read by the testbench at the end of the run
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module cart_info_asserts
	import cart_pkg::*;
(
	input wire       clk_sys,
	input wire       RESET_N,
	input wire       cart_wr,
	input wire       cart_active,
	input rom_type_t rom_type,
	input mask_t     rom_mask,
	input mask_t     ram_mask
);

	int unsigned fail_count = 0;

	// Outputs hold for the whole cartridge download
	hold_during_download: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		cart_active |=> $stable(rom_type) && $stable(rom_mask) && $stable(ram_mask))
	else begin
		fail_count++;
		$error("rom_type or a mask changed while cart_active was high");
	end

	// All ones below the top bit
	rom_mask_shape: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		((rom_mask + mask_t'(1)) & rom_mask) == mask_t'(0))
	else begin
		fail_count++;
		$error("rom_mask is not one less than a power of two");
	end

	wr_inside_download: assert property (@(posedge clk_sys) disable iff (!RESET_N)
		$rose(cart_wr) |-> cart_active)
	else begin
		fail_count++;
		$error("cart_wr rose outside a cartridge download");
	end

endmodule

bind cart_info_top cart_info_asserts cart_info_asserts_i (
	.clk_sys     (clk_sys),
	.RESET_N     (RESET_N),
	.cart_wr     (cart_wr),
	.cart_active (cart_active),
	.rom_type    (rom_type),
	.rom_mask    (rom_mask),
	.ram_mask    (ram_mask)
);

`default_nettype wire

//--- verif/cart_info_tb.sv
//==========================================================
// Table driven testbench for cart_info_top
// Each row downloads one ROM header and checks the outputs
// 3 cycles after load_active falls
// Row 7 depends on the fields left by row 6
// The sound file sequence runs after the table
//==========================================================

`timescale 1ns/1ps
`default_nettype none

module cart_info_tb
	import cart_pkg::*;
();

	typedef struct packed {
		rom_layout_t layout;
		logic        copier;
		logic        shift;
		byte_t       mapper;
		byte_t       typ;
		size_code_t  rom_size;
		size_code_t  ram_size;
		byte_t       company;
		rom_type_t   exp_type;
		mask_t       exp_rom_mask;
		mask_t       exp_ram_mask;
	} row_t;

	logic        clk_sys;
	logic        RESET_N;
	logic        load_wr;
	logic        load_active;
	logic [5:0]  load_index;
	load_addr_t  load_addr;
	load_data_t  load_data;
	file_size_t  load_size;
	rom_layout_t rom_layout;
	logic        reset_req;
	rom_type_t   rom_type;
	mask_t       rom_mask;
	mask_t       ram_mask;
	logic        sound_mode;

	row_t        rows[$];
	string       names[$];
	int unsigned cycle_count = 0;
	int unsigned timeout_limit = 0;

	cart_info_top cart_info_top_i (.*);

	always #5 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (timeout_limit != 0 && cycle_count >= timeout_limit) begin
			$display("Timeout after %0d cycles, the test did not finish", cycle_count);
			$display("Test FAILED");
			$fatal(1, "Simulation stopped by the timeout");
		end
	end

	task automatic add_row(input string name, input rom_layout_t layout, input logic copier,
	                       input logic shift, input byte_t mapper, input byte_t typ,
	                       input size_code_t rom_size, input size_code_t ram_size,
	                       input byte_t company, input rom_type_t exp_type,
	                       input mask_t exp_rom_mask, input mask_t exp_ram_mask);
		row_t r;
		r = '{layout, copier, shift, mapper, typ, rom_size, ram_size, company,
		      exp_type, exp_rom_mask, exp_ram_mask};
		rows.push_back(r);
		names.push_back(name);
	endtask

	task automatic check_rom_type(input string name, input rom_type_t expected,
	                              input rom_type_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s rom_type: expected 0x%02h, actual 0x%02h",
			         name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "rom_type check failed");
		end
	endtask

	task automatic check_mask(input string name, input mask_t expected, input mask_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected 0x%06h, actual 0x%06h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "Mask check failed");
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %b, actual %b", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "Flag check failed");
		end
	endtask

	// Header word address of each layout, copier header not included
	function automatic load_addr_t header_base(input rom_layout_t layout);
		case (layout)
			2'd1:    return 25'h000FFD4;
			2'd2:    return 25'h040FFD4;
			default: return 25'h0007FD4;
		endcase
	endfunction

	task automatic start_download(input logic [5:0] index, input file_size_t size);
		@(negedge clk_sys);
		load_active = 1'b1;
		load_index  = index;
		load_size   = size;
	endtask

	task automatic write_word(input load_addr_t addr, input load_data_t data);
		@(negedge clk_sys);
		load_addr = addr;
		load_data = data;
		load_wr   = 1'b1;
		@(negedge clk_sys);
		load_wr   = 1'b0;
	endtask

	task automatic end_download();
		@(negedge clk_sys);
		load_active = 1'b0;
		repeat (3) @(negedge clk_sys);
	endtask

	task automatic check_outputs(input string name, input row_t r);
		check_rom_type(name, r.exp_type, rom_type);
		check_mask($sformatf("%s rom_mask", name), r.exp_rom_mask, rom_mask);
		check_mask($sformatf("%s ram_mask", name), r.exp_ram_mask, ram_mask);
	endtask

	task automatic run_row(input int idx);
		row_t       r;
		load_addr_t start_addr;
		load_addr_t base;
		r = rows[idx];
		start_addr = r.copier ? 25'd512 : 25'd0;
		base = header_base(r.layout) + (r.shift ? 25'd512 : 25'd0);
		rom_layout = r.layout;
		start_download(6'd0, r.copier ? 24'd512 : 24'd0);
		write_word(start_addr, 16'h0000);
		write_word(base, {r.mapper, 8'h00});
		write_word(base + 25'd2, {4'h0, r.rom_size, r.typ});
		write_word(base + 25'd4, {12'h000, r.ram_size});
		write_word(base + 25'd6, {8'h00, r.company});
		write_word(base + 25'd16, 16'hFFFF);
		end_download();
		check_outputs(names[idx], r);
	endtask

	task automatic pulse_reset_req();
		@(negedge clk_sys);
		reset_req = 1'b1;
		@(negedge clk_sys);
		reset_req = 1'b0;
	endtask

	initial begin
		clk_sys     = 1'b0;
		RESET_N     = 1'b0;
		load_wr     = 1'b0;
		load_active = 1'b0;
		load_index  = 6'd0;
		load_addr   = '0;
		load_data   = '0;
		load_size   = '0;
		rom_layout  = 2'd0;
		reset_req   = 1'b0;

		// name, layout, copier, shift, mapper, type, rom, ram, company, type, rom mask, ram mask
		add_row("dsp1_lorom",       0, 0, 0, 'h20, 'h03, 10, 0, 'h00, 'h80, 'h0FFFFF, 'h0);
		add_row("dsp1_hirom",       1, 0, 0, 'h21, 'h03, 11, 1, 'h00, 'h81, 'h1FFFFF, 'h7FF);
		add_row("dsp1_exhirom",     2, 0, 0, 'h31, 'h05, 13, 3, 'h00, 'h82, 'h7FFFFF, 'h1FFF);
		add_row("dsp2_copier",      0, 1, 1, 'h20, 'h05, 10, 0, 'h00, 'h90, 'h0FFFFF, 'h0);
		add_row("dsp1_copier_hi",   1, 1, 1, 'h20, 'h03, 5,  3, 'h00, 'h81, 'h3FFFFF, 'h1FFF);
		add_row("unknown_mapper",   0, 0, 0, 'h55, 'h03, 12, 2, 'h00, 'h00, 'h3FFFFF, 'hFFF);
		add_row("copier_unshifted", 1, 1, 0, 'h20, 'h03, 10, 5, 'hB2, 'h01, 'h3FFFFF, 'h0);
		add_row("dsp3_company",     0, 0, 0, 'h30, 'h05, 10, 0, 'hB2, 'hA0, 'h0FFFFF, 'h0);
		add_row("dsp1_mapper30",    0, 0, 0, 'h30, 'h05, 11, 1, 'h33, 'h80, 'h1FFFFF, 'h7FF);
		add_row("dsp4",             0, 0, 0, 'h30, 'h03, 10, 0, 'h00, 'hB0, 'h0FFFFF, 'h0);
		add_row("obc1",             0, 0, 0, 'h30, 'h25, 10, 3, 'h00, 'hC0, 'h0FFFFF, 'h1FFF);
		add_row("sdd1",             0, 0, 0, 'h32, 'h43, 12, 3, 'h00, 'h50, 'h3FFFFF, 'h1FFF);
		add_row("st0xx_small",      0, 0, 0, 'h30, 'hF6, 9,  0, 'h00, 'hA8, 'h07FFFF, 'h0);
		add_row("st0xx_large",      0, 0, 0, 'h30, 'hF6, 10, 0, 'h00, 'h88, 'h0FFFFF, 'h0);
		add_row("gsu_ram3",         0, 0, 0, 'h20, 'h15, 10, 3, 'h00, 'h70, 'h0FFFFF, 'hFFFF);
		add_row("gsu_ram0",         0, 0, 0, 'h20, 'h1A, 10, 0, 'h00, 'h70, 'h0FFFFF, 'hFFFF);
		add_row("sa1",              0, 0, 0, 'h23, 'h35, 11, 3, 'h00, 'h60, 'h1FFFFF, 'h1FFF);
		add_row("spc7110_rtc",      1, 0, 0, 'h3A, 'hF9, 13, 3, 'h00, 'hD9, 'h7FFFFF, 'h1FFF);
		add_row("spc7110",          1, 0, 0, 'h3A, 'hF5, 13, 3, 'h00, 'hD1, 'h7FFFFF, 'h1FFF);
		add_row("cx4",              0, 0, 0, 'h20, 'hF3, 10, 0, 'h00, 'h40, 'h0FFFFF, 'h0);
		timeout_limit = rows.size() * 40 + 50;

		repeat (2) @(negedge clk_sys);
		RESET_N = 1'b1;
		check_rom_type("after_reset", 8'h00, rom_type);
		check_mask("after_reset rom_mask", 24'h000000, rom_mask);
		check_mask("after_reset ram_mask", 24'h000000, ram_mask);
		check_flag("after_reset sound_mode", 1'b0, sound_mode);

		for (int i = 0; i < rows.size(); i++)
			run_row(i);

		//==========================================================
		// Sound file mode, last cartridge must stay classified
		//==========================================================
		start_download(SPC_INDEX, 24'd0);
		write_word(25'h0, 16'h1234);
		check_flag("spc_write", 1'b1, sound_mode);
		end_download();
		check_outputs("after_spc", rows[rows.size() - 1]);

		start_download(6'd0, 24'd0);
		write_word(25'h100, 16'h0000);
		check_flag("cart_write", 1'b0, sound_mode);
		end_download();
		check_outputs("after_cart_write", rows[rows.size() - 1]);

		start_download(SPC_INDEX, 24'd0);
		write_word(25'h2, 16'h5678);
		check_flag("spc_again", 1'b1, sound_mode);
		end_download();
		pulse_reset_req();
		check_flag("reset_req", 1'b0, sound_mode);
		check_outputs("after_reset_req", rows[rows.size() - 1]);

		if (cart_info_top_i.cart_info_asserts_i.fail_count != 0) begin
			$display("%0d assertion failures", cart_info_top_i.cart_info_asserts_i.fail_count);
			$display("Test FAILED");
			$fatal(1, "Assertions failed");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

endmodule

`default_nettype wire
